// ==== src/mipsIsaPkg.sv ====
package mipsIsaPkg;

    localparam int DataW   = 32;
    localparam int RegIdxW = 5;
    localparam int ShamtW  = 5;
    localparam int OpcodeW = 6;
    localparam int FunctW  = 6;
    localparam int NumRegs = 32;

    typedef logic [DataW-1:0]   wordT;
    typedef logic [RegIdxW-1:0] regIdxT;

    localparam regIdxT RegRa = 5'd31;  // jal link register

    // primary opcodes, instr[31:26]
    typedef enum logic [OpcodeW-1:0] {
        OpSpecial = 6'h00,
        OpJ       = 6'h02,
        OpJal     = 6'h03,
        OpBeq     = 6'h04,
        OpBne     = 6'h05,
        OpAddiu   = 6'h09,
        OpSlti    = 6'h0a,
        OpAndi    = 6'h0c,
        OpOri     = 6'h0d,
        OpXori    = 6'h0e,
        OpLui     = 6'h0f,
        OpLb      = 6'h20,
        OpLw      = 6'h23,
        OpLbu     = 6'h24,
        OpSb      = 6'h28,
        OpSw      = 6'h2b
    } opcodeE;

    // SPECIAL function codes, instr[5:0]
    typedef enum logic [FunctW-1:0] {
        FnSll  = 6'h00,
        FnSrl  = 6'h02,
        FnSra  = 6'h03,
        FnAddu = 6'h21,
        FnSubu = 6'h23,
        FnAnd  = 6'h24,
        FnOr   = 6'h25,
        FnXor  = 6'h26,
        FnNor  = 6'h27,
        FnSlt  = 6'h2a,
        FnSltu = 6'h2b
    } functE;

endpackage

// ==== src/pipePkg.sv ====
package pipePkg;

    import mipsIsaPkg::*;

    typedef enum logic [3:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluXor,
        AluNor,
        AluSlt,
        AluSltu,
        AluSll,
        AluSrl,
        AluSra,
        AluLui
    } aluOpE;

    typedef enum logic {
        MemWord,
        MemByte
    } memSizeE;

    // where a decode operand comes from
    typedef enum logic [1:0] {
        FwdRegFile,
        FwdExec,
        FwdMem,
        FwdWb
    } fwdSelE;

    typedef struct packed {
        aluOpE   aluOp;
        logic    useImm;      // operand B from immediate
        logic    regWrite;
        logic    memRead;
        logic    memWrite;
        memSizeE memSize;
        logic    loadSigned;  // lb vs lbu
        logic    isLink;      // jal, result is pc+8
    } ctrlT;

    typedef struct packed {
        ctrlT              ctrl;
        wordT              pc;
        wordT              opA;
        wordT              opB;
        wordT              storeData;
        regIdxT            dest;
        logic [ShamtW-1:0] shamt;
        logic              valid;
    } idExT;

    typedef struct packed {
        ctrlT   ctrl;
        wordT   pc;
        wordT   result;     // alu result or link address, also the memory address
        wordT   storeData;
        regIdxT dest;
        logic   valid;
    } exMemT;

    typedef struct packed {
        wordT   pc;
        wordT   result;
        regIdxT dest;
        logic   regWrite;
        logic   valid;
    } memWbT;

endpackage

// ==== src/fetchStage.sv ====
`timescale 1ns/1ns

module fetchStage import mipsIsaPkg::*; #(
    parameter wordT ResetPc = 32'hbfc0_0000
) (
    input  logic clk,
    input  logic reset_i,
    input  logic hold_i,      // freeze or load-use stall
    input  logic redirect_i,  // taken branch or jump sitting in decode
    input  wordT target_i,
    output wordT pc_o,
    output logic instEn_o
);

    wordT pcQ;
    wordT pcNext;

    // delay slot is already in F when the redirect arrives
    assign pcNext = redirect_i ? target_i : pcQ + 32'd4;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pcQ <= ResetPc;
        end else if (!hold_i) begin
            pcQ <= pcNext;
        end
    end

    assign pc_o     = pcQ;
    assign instEn_o = ~reset_i;  // no fetch while in reset

endmodule

// ==== src/decodeUnit.sv ====
`timescale 1ns/1ns

module decodeUnit import mipsIsaPkg::*, pipePkg::*; (
    input  wordT   instr_i,
    output ctrlT   ctrl_o,
    output wordT   imm_o,
    output regIdxT dest_o,
    output logic   isBranch_o,
    output logic   branchNe_o,
    output logic   isJump_o
);

    opcodeE op;
    functE  fn;
    logic   zeroExt;
    ctrlT   ctrl;
    regIdxT dest;

    assign op = opcodeE'(instr_i[31:26]);
    assign fn = functE'(instr_i[5:0]);

    // logical immediates are zero extended
    assign zeroExt = (op == OpAndi) || (op == OpOri) || (op == OpXori);
    assign imm_o   = zeroExt ? {16'b0, instr_i[15:0]} : {{16{instr_i[15]}}, instr_i[15:0]};

    always_comb begin
        ctrl       = '0;  // nop
        dest       = instr_i[20:16];
        isBranch_o = 1'b0;
        branchNe_o = 1'b0;
        isJump_o   = 1'b0;
        case (op)
            OpSpecial: begin
                dest          = instr_i[15:11];
                ctrl.regWrite = 1'b1;
                case (fn)
                    FnAddu:  ctrl.aluOp = AluAdd;
                    FnSubu:  ctrl.aluOp = AluSub;
                    FnAnd:   ctrl.aluOp = AluAnd;
                    FnOr:    ctrl.aluOp = AluOr;
                    FnXor:   ctrl.aluOp = AluXor;
                    FnNor:   ctrl.aluOp = AluNor;
                    FnSlt:   ctrl.aluOp = AluSlt;
                    FnSltu:  ctrl.aluOp = AluSltu;
                    FnSll:   ctrl.aluOp = AluSll;
                    FnSrl:   ctrl.aluOp = AluSrl;
                    FnSra:   ctrl.aluOp = AluSra;
                    default: ctrl.regWrite = 1'b0;
                endcase
            end
            OpAddiu, OpSlti, OpAndi, OpOri, OpXori, OpLui: begin
                ctrl.useImm   = 1'b1;
                ctrl.regWrite = 1'b1;
                case (op)
                    OpSlti:  ctrl.aluOp = AluSlt;
                    OpAndi:  ctrl.aluOp = AluAnd;
                    OpOri:   ctrl.aluOp = AluOr;
                    OpXori:  ctrl.aluOp = AluXor;
                    OpLui:   ctrl.aluOp = AluLui;
                    default: ctrl.aluOp = AluAdd;
                endcase
            end
            OpLw, OpLb, OpLbu: begin
                ctrl.useImm     = 1'b1;  // base + offset through the adder
                ctrl.regWrite   = 1'b1;
                ctrl.memRead    = 1'b1;
                ctrl.memSize    = (op == OpLw) ? MemWord : MemByte;
                ctrl.loadSigned = (op == OpLb);
            end
            OpSw, OpSb: begin
                ctrl.useImm   = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.memSize  = (op == OpSw) ? MemWord : MemByte;
            end
            OpBeq, OpBne: begin
                isBranch_o = 1'b1;
                branchNe_o = (op == OpBne);
            end
            OpJ: isJump_o = 1'b1;
            OpJal: begin
                isJump_o      = 1'b1;
                ctrl.isLink   = 1'b1;
                ctrl.regWrite = 1'b1;
                dest          = RegRa;
            end
            default: ctrl = '0;
        endcase
        if (dest == '0) begin
            ctrl.regWrite = 1'b0;  // $zero never written
        end
    end

    assign ctrl_o = ctrl;
    assign dest_o = dest;

endmodule

// ==== src/regFile.sv ====
`timescale 1ns/1ns

module regFile import mipsIsaPkg::*; (
    input  logic   clk,
    input  logic   reset_i,
    input  logic   we_i,
    input  regIdxT waddr_i,
    input  wordT   wdata_i,
    input  regIdxT raddr1_i,
    input  regIdxT raddr2_i,
    output wordT   rdata1_o,
    output wordT   rdata2_o
);

    wordT regs [NumRegs];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // write-then-read in the same cycle is handled by the wb forward
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// ==== src/alu.sv ====
`timescale 1ns/1ns

module alu import mipsIsaPkg::*, pipePkg::*; (
    input  aluOpE             op_i,
    input  wordT              a_i,
    input  wordT              b_i,
    input  logic [ShamtW-1:0] shamt_i,
    output wordT              result_o
);

    logic ltSigned;
    logic ltUnsigned;

    assign ltSigned   = $signed(a_i) < $signed(b_i);
    assign ltUnsigned = a_i < b_i;

    always_comb begin
        case (op_i)
            AluAdd:  result_o = a_i + b_i;  // addu, addiu, load/store address
            AluSub:  result_o = a_i - b_i;
            AluAnd:  result_o = a_i & b_i;
            AluOr:   result_o = a_i | b_i;
            AluXor:  result_o = a_i ^ b_i;
            AluNor:  result_o = ~(a_i | b_i);
            AluSlt:  result_o = {{(DataW-1){1'b0}}, ltSigned};
            AluSltu: result_o = {{(DataW-1){1'b0}}, ltUnsigned};
            // shifts act on rt
            AluSll:  result_o = b_i << shamt_i;
            AluSrl:  result_o = b_i >> shamt_i;
            AluSra:  result_o = wordT'($signed(b_i) >>> shamt_i);
            AluLui:  result_o = {b_i[15:0], 16'b0};
            default: result_o = a_i + b_i;
        endcase
    end

endmodule

// ==== src/hazardUnit.sv ====
`timescale 1ns/1ns

module hazardUnit import mipsIsaPkg::*, pipePkg::*; (
    input  regIdxT rsD_i,
    input  regIdxT rtD_i,
    input  regIdxT destE_i,
    input  logic   regWriteE_i,
    input  logic   memReadE_i,
    input  regIdxT destM_i,
    input  logic   regWriteM_i,
    input  regIdxT destW_i,
    input  logic   regWriteW_i,
    input  logic   iCacheStall_i,
    input  logic   dCacheStall_i,
    output fwdSelE fwdA_o,
    output fwdSelE fwdB_o,
    output logic   stallFd_o,
    output logic   freeze_o
);

    // youngest producer wins, load in E is left to the interlock
    function automatic fwdSelE pickSrc(regIdxT src);
        fwdSelE sel;
        if (src == '0) begin
            sel = FwdRegFile;
        end else if (regWriteE_i && !memReadE_i && destE_i == src) begin
            sel = FwdExec;
        end else if (regWriteM_i && destM_i == src) begin
            sel = FwdMem;
        end else if (regWriteW_i && destW_i == src) begin
            sel = FwdWb;
        end else begin
            sel = FwdRegFile;
        end
        return sel;
    endfunction

    always_comb begin
        fwdA_o = pickSrc(rsD_i);
        fwdB_o = pickSrc(rtD_i);
    end

    // load result only exists in M, hold decode one cycle
    assign stallFd_o = memReadE_i && destE_i != '0
                       && (destE_i == rsD_i || destE_i == rtD_i);

    assign freeze_o = iCacheStall_i | dCacheStall_i;

endmodule

// ==== src/memAccess.sv ====
`timescale 1ns/1ns

module memAccess import mipsIsaPkg::*, pipePkg::*; (
    input  memSizeE    size_i,
    input  logic       loadSigned_i,
    input  wordT       addr_i,
    input  wordT       storeData_i,
    input  wordT       rdata_i,
    output logic [3:0] writeSel_o,
    output wordT       wdata_o,
    output wordT       loadData_o
);

    logic [1:0] lane;
    logic [7:0] loadByte;

    assign lane = addr_i[1:0];

    // store side
    always_comb begin
        if (size_i == MemByte) begin
            writeSel_o = 4'b0001 << lane;
            wdata_o    = {4{storeData_i[7:0]}};  // byte on every lane
        end else begin
            writeSel_o = 4'b1111;
            wdata_o    = storeData_i;
        end
    end

    // load side
    always_comb begin
        case (lane)
            2'd0:    loadByte = rdata_i[7:0];
            2'd1:    loadByte = rdata_i[15:8];
            2'd2:    loadByte = rdata_i[23:16];
            default: loadByte = rdata_i[31:24];
        endcase
    end

    always_comb begin
        if (size_i == MemWord) begin
            loadData_o = rdata_i;
        end else if (loadSigned_i) begin
            loadData_o = {{24{loadByte[7]}}, loadByte};  // lb
        end else begin
            loadData_o = {24'b0, loadByte};  // lbu
        end
    end

endmodule

// ==== src/datapath.sv ====
`timescale 1ns/1ns

module datapath import mipsIsaPkg::*, pipePkg::*; #(
    parameter wordT ResetPc = 32'hbfc0_0000
) (
    input  logic       clk,
    input  logic       reset_i,
    output logic       instEn_o,
    output wordT       pcF_o,
    input  wordT       instr_i,
    input  logic       iCacheStall_i,
    input  logic       dCacheStall_i,
    output logic       memEn_o,
    output wordT       memAddr_o,
    input  wordT       memRdata_i,
    output logic [3:0] memWriteSel_o,
    output wordT       memWdata_o,
    output wordT       debugWbPc_o,
    output logic [3:0] debugWbRfWen_o,
    output regIdxT     debugWbRfWnum_o,
    output wordT       debugWbRfWdata_o
);

    wordT       instrD;
    wordT       pcD;
    logic       validD;
    idExT       idEx;
    idExT       idExNext;
    exMemT      exMem;
    memWbT      memWb;
    ctrlT       ctrlD;
    wordT       immD;
    wordT       rd1D;
    wordT       rd2D;
    wordT       srcAD;
    wordT       srcBD;
    wordT       pcPlus4D;
    wordT       target;
    regIdxT     destD;
    logic       isBranchD;
    logic       branchNeD;
    logic       isJumpD;
    logic       redirect;
    fwdSelE     fwdA;
    fwdSelE     fwdB;
    logic       stallFd;
    logic       freeze;
    wordT       aluOutE;
    wordT       exResult;
    wordT       loadDataM;
    wordT       memResult;
    logic [3:0] writeSelM;
    logic       wbWen;

    function automatic wordT pickFwd(fwdSelE sel, wordT rf, wordT ex, wordT mem, wordT wb);
        case (sel)
            FwdExec: return ex;
            FwdMem:  return mem;
            FwdWb:   return wb;
            default: return rf;
        endcase
    endfunction

    fetchStage #(.ResetPc(ResetPc)) fetch0 (
        .clk       (clk),
        .reset_i   (reset_i),
        .hold_i    (freeze | stallFd),
        .redirect_i(redirect),
        .target_i  (target),
        .pc_o      (pcF_o),
        .instEn_o  (instEn_o)
    );

    always_ff @(posedge clk) begin
        if (reset_i) begin
            validD <= 1'b0;
            instrD <= '0;
            pcD    <= '0;
        end else if (!freeze && !stallFd) begin
            validD <= instEn_o;
            instrD <= instr_i;
            pcD    <= pcF_o;
        end
    end

    decodeUnit dec0 (
        .instr_i   (instrD),
        .ctrl_o    (ctrlD),
        .imm_o     (immD),
        .dest_o    (destD),
        .isBranch_o(isBranchD),
        .branchNe_o(branchNeD),
        .isJump_o  (isJumpD)
    );

    regFile rf0 (
        .clk     (clk),
        .reset_i (reset_i),
        .we_i    (wbWen),
        .waddr_i (memWb.dest),
        .wdata_i (memWb.result),
        .raddr1_i(instrD[25:21]),
        .raddr2_i(instrD[20:16]),
        .rdata1_o(rd1D),
        .rdata2_o(rd2D)
    );

    hazardUnit hz0 (
        .rsD_i        (instrD[25:21]),
        .rtD_i        (instrD[20:16]),
        .destE_i      (idEx.dest),
        .regWriteE_i  (idEx.ctrl.regWrite & idEx.valid),
        .memReadE_i   (idEx.ctrl.memRead & idEx.valid),
        .destM_i      (exMem.dest),
        .regWriteM_i  (exMem.ctrl.regWrite & exMem.valid),
        .destW_i      (memWb.dest),
        .regWriteW_i  (memWb.regWrite & memWb.valid),
        .iCacheStall_i(iCacheStall_i),
        .dCacheStall_i(dCacheStall_i),
        .fwdA_o       (fwdA),
        .fwdB_o       (fwdB),
        .stallFd_o    (stallFd),
        .freeze_o     (freeze)
    );

    assign srcAD = pickFwd(fwdA, rd1D, exResult, memResult, memWb.result);
    assign srcBD = pickFwd(fwdB, rd2D, exResult, memResult, memWb.result);

    // branch resolve in decode
    assign pcPlus4D = pcD + 32'd4;
    assign redirect = validD & (isJumpD | (isBranchD & ((srcAD == srcBD) ^ branchNeD)));
    assign target   = isJumpD ? {pcPlus4D[31:28], instrD[25:0], 2'b00}
                              : pcPlus4D + {immD[29:0], 2'b00};

    assign idExNext = '{ctrl: ctrlD, pc: pcD, opA: srcAD,
                        opB: ctrlD.useImm ? immD : srcBD, storeData: srcBD,
                        dest: destD, shamt: instrD[10:6], valid: validD};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            idEx <= '0;
        end else if (!freeze) begin
            idEx <= (stallFd || !validD) ? '0 : idExNext;  // bubble on load-use
        end
    end

    alu alu0 (
        .op_i    (idEx.ctrl.aluOp),
        .a_i     (idEx.opA),
        .b_i     (idEx.opB),
        .shamt_i (idEx.shamt),
        .result_o(aluOutE)
    );

    assign exResult = idEx.ctrl.isLink ? idEx.pc + 32'd8 : aluOutE;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            exMem <= '0;
        end else if (!freeze) begin
            exMem <= '{ctrl: idEx.ctrl, pc: idEx.pc, result: exResult,
                       storeData: idEx.storeData, dest: idEx.dest, valid: idEx.valid};
        end
    end

    memAccess mem0 (
        .size_i      (exMem.ctrl.memSize),
        .loadSigned_i(exMem.ctrl.loadSigned),
        .addr_i      (exMem.result),
        .storeData_i (exMem.storeData),
        .rdata_i     (memRdata_i),
        .writeSel_o  (writeSelM),
        .wdata_o     (memWdata_o),
        .loadData_o  (loadDataM)
    );

    assign memEn_o       = exMem.valid & (exMem.ctrl.memRead | exMem.ctrl.memWrite);
    assign memAddr_o     = {exMem.result[31:2], 2'b00};
    assign memWriteSel_o = (exMem.valid & exMem.ctrl.memWrite) ? writeSelM : 4'b0000;
    assign memResult     = exMem.ctrl.memRead ? loadDataM : exMem.result;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            memWb <= '0;
        end else if (!freeze) begin
            memWb <= '{pc: exMem.pc, result: memResult, dest: exMem.dest,
                       regWrite: exMem.ctrl.regWrite, valid: exMem.valid};
        end
    end

    // held in W during a freeze, so write only once
    assign wbWen = memWb.regWrite & memWb.valid & ~freeze;

    assign debugWbPc_o      = memWb.pc;
    assign debugWbRfWen_o   = {4{wbWen}};
    assign debugWbRfWnum_o  = memWb.dest;
    assign debugWbRfWdata_o = memWb.result;

endmodule

// ==== tests/datapathTb.sv ====
`timescale 1ns/1ns

module datapathTb import mipsIsaPkg::*; ();

    localparam wordT ResetPc        = 32'hbfc0_0000;
    localparam int   ProgWords      = 256;  // random part, then self-jump and nop
    localparam int   ImemWords      = ProgWords + 2;
    localparam wordT EndPc          = ResetPc + 32'(4 * ProgWords);
    localparam int   DmemWords      = 16;   // 64-byte data region at address 0
    localparam int   ResetCycles    = 16;
    localparam int   DrainCycles    = 50;
    // program needs a few hundred cycles even with stalls on every third cycle
    localparam int   WatchdogCycles = 20000;

    typedef struct packed {
        wordT   pc;
        regIdxT num;
        wordT   data;
    } regWriteT;

    typedef struct packed {
        wordT       addr;
        logic [3:0] sel;
        wordT       data;
    } storeT;

    logic       clk;
    logic       reset_i;
    logic       instEn_o;
    wordT       pcF_o;
    wordT       instr_i;
    logic       iCacheStall_i;
    logic       dCacheStall_i;
    logic       memEn_o;
    wordT       memAddr_o;
    wordT       memRdata_i;
    logic [3:0] memWriteSel_o;
    wordT       memWdata_o;
    wordT       debugWbPc_o;
    logic [3:0] debugWbRfWen_o;
    regIdxT     debugWbRfWnum_o;
    wordT       debugWbRfWdata_o;

    wordT     imem [ImemWords];
    wordT     dmem [DmemWords];
    wordT     imemIdx;
    regWriteT expRegs [$];
    storeT    expStores [$];

    functE  regFns [11] = '{FnAddu, FnSubu, FnAnd, FnOr, FnXor, FnNor,
                            FnSlt, FnSltu, FnSll, FnSrl, FnSra};
    opcodeE immOps [6]  = '{OpAddiu, OpSlti, OpAndi, OpOri, OpXori, OpLui};

    datapath #(.ResetPc(ResetPc)) dut0 (
        .clk             (clk),
        .reset_i         (reset_i),
        .instEn_o        (instEn_o),
        .pcF_o           (pcF_o),
        .instr_i         (instr_i),
        .iCacheStall_i   (iCacheStall_i),
        .dCacheStall_i   (dCacheStall_i),
        .memEn_o         (memEn_o),
        .memAddr_o       (memAddr_o),
        .memRdata_i      (memRdata_i),
        .memWriteSel_o   (memWriteSel_o),
        .memWdata_o      (memWdata_o),
        .debugWbPc_o     (debugWbPc_o),
        .debugWbRfWen_o  (debugWbRfWen_o),
        .debugWbRfWnum_o (debugWbRfWnum_o),
        .debugWbRfWdata_o(debugWbRfWdata_o)
    );

    // both memories answer in the same cycle
    assign imemIdx    = (pcF_o - ResetPc) >> 2;
    assign instr_i    = (imemIdx < ImemWords) ? imem[imemIdx] : 32'h0000_0000;
    assign memRdata_i = dmem[memAddr_o[5:2]];

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stopWithError(string msg);
        $display("%0t ns: %s", $time, msg);
        $display("TEST FAIL");
        $fatal(1, "%s", msg);
    endtask

    task automatic compareValue(string name, wordT got, wordT exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    // initial data word, a function of its byte address
    function automatic wordT fillWord(int idx);
        return (32'(idx * 4) * 32'h9e37_79b9) ^ 32'hc3a5_0f1e;
    endfunction

    function automatic int pickSrc();
        return 1 + $urandom % 7;  // r1..r7 keeps hazards dense
    endfunction

    function automatic int pickDest();
        return $urandom % 8;  // r0 included, such writes must vanish
    endfunction

    function automatic wordT encR(int rs, int rt, int rd, int sh, functE fn);
        return {OpSpecial, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
    endfunction

    function automatic wordT encI(opcodeE op, int rs, int rt, int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic wordT encJ(opcodeE op, int tIdx);
        wordT tgt;
        tgt = ResetPc + 32'(4 * tIdx);
        return {op, tgt[27:2]};
    endfunction

    task automatic genProgram();
        int   kind;
        int   k;
        bit   prevCtrl;
        wordT w;
        prevCtrl = 1'b0;
        for (int idx = 0; idx < ProgWords; idx++) begin
            // no control in a delay slot, and no slot that lands on the self-jump
            if (!prevCtrl && idx < ProgWords - 1) begin
                kind = $urandom % 26;
            end else begin
                kind = $urandom % 22;
            end
            if (kind < 8) begin
                w = encR(pickSrc(), pickSrc(), pickDest(), 0, regFns[kind]);
            end else if (kind < 11) begin
                w = encR(0, pickSrc(), pickDest(), $urandom % 32, regFns[kind]);  // shifts
            end else if (kind < 17) begin
                w = encI(immOps[kind - 11], (kind == 16) ? 0 : pickSrc(), pickDest(), $urandom);
            end else begin
                case (kind)
                    17: w = encI(OpLw, 0, pickDest(), 4 * ($urandom % 16));
                    18: w = encI(OpLb, 0, pickDest(), $urandom % 64);
                    19: w = encI(OpLbu, 0, pickDest(), $urandom % 64);
                    20: w = encI(OpSw, 0, pickSrc(), 4 * ($urandom % 16));
                    21: w = encI(OpSb, 0, pickSrc(), $urandom % 64);
                    22, 23: begin
                        k = 1 + $urandom % 4;  // target 2..5 words ahead
                        if (idx + 1 + k > ProgWords) begin
                            k = ProgWords - 1 - idx;
                        end
                        w = encI((kind == 22) ? OpBeq : OpBne, pickSrc(), pickSrc(), k);
                    end
                    default: begin
                        k = idx + 2 + $urandom % 4;
                        if (k > ProgWords) begin
                            k = ProgWords;
                        end
                        w = encJ((kind == 24) ? OpJ : OpJal, k);
                    end
                endcase
            end
            imem[idx] = w;
            prevCtrl  = (kind >= 22);
        end
        imem[ProgWords]     = encJ(OpJ, ProgWords);  // park here
        imem[ProgWords + 1] = 32'h0000_0000;
    endtask

    function automatic wordT specialResult(wordT instr, wordT a, wordT b);
        logic [4:0] sh;
        sh = instr[10:6];
        case (functE'(instr[5:0]))
            FnAddu:  return a + b;
            FnSubu:  return a - b;
            FnAnd:   return a & b;
            FnOr:    return a | b;
            FnXor:   return a ^ b;
            FnNor:   return ~(a | b);
            FnSlt:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            FnSltu:  return (a < b) ? 32'd1 : 32'd0;
            FnSll:   return b << sh;
            FnSrl:   return b >> sh;
            FnSra:   return $unsigned($signed(b) >>> sh);
            default: return 32'd0;
        endcase
    endfunction

    // instruction-level execution with one delay slot
    task automatic runModel();
        wordT       regs [32];
        wordT       mdl [DmemWords];
        wordT       pc;
        wordT       pc4;
        wordT       npc;
        wordT       nextNpc;
        wordT       instr;
        wordT       a;
        wordT       b;
        wordT       simm;
        wordT       zimm;
        wordT       addr;
        wordT       wdata;
        regIdxT     wnum;
        logic [7:0] bt;
        logic       wr;
        int         steps;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < DmemWords; i++) begin
            mdl[i] = fillWord(i);
        end
        pc    = ResetPc;
        npc   = ResetPc + 32'd4;
        steps = 0;
        while (pc != EndPc) begin
            if (steps > 2 * ImemWords) begin
                stopWithError("reference model never reached the end of the program");
            end
            steps++;
            instr   = imem[(pc - ResetPc) >> 2];
            a       = regs[instr[25:21]];
            b       = regs[instr[20:16]];
            simm    = {{16{instr[15]}}, instr[15:0]};
            zimm    = {16'b0, instr[15:0]};
            addr    = a + simm;
            bt      = mdl[addr[5:2]][8*addr[1:0] +: 8];
            pc4     = pc + 32'd4;
            nextNpc = npc + 32'd4;
            wr      = 1'b1;
            wnum    = instr[20:16];
            wdata   = '0;
            case (opcodeE'(instr[31:26]))
                OpSpecial: begin
                    wnum  = instr[15:11];
                    wdata = specialResult(instr, a, b);
                end
                OpAddiu: wdata = a + simm;
                OpSlti:  wdata = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
                OpAndi:  wdata = a & zimm;
                OpOri:   wdata = a | zimm;
                OpXori:  wdata = a ^ zimm;
                OpLui:   wdata = {instr[15:0], 16'b0};
                OpLw:    wdata = mdl[addr[5:2]];
                OpLb:    wdata = {{24{bt[7]}}, bt};
                OpLbu:   wdata = {24'b0, bt};
                OpSw: begin
                    wr             = 1'b0;
                    mdl[addr[5:2]] = b;
                    expStores.push_back(storeT'{{addr[31:2], 2'b00}, 4'b1111, b});
                end
                OpSb: begin
                    wr = 1'b0;
                    mdl[addr[5:2]][8*addr[1:0] +: 8] = b[7:0];
                    // byte shows on every lane, only its own lane enabled
                    expStores.push_back(storeT'{{addr[31:2], 2'b00}, 4'b0001 << addr[1:0],
                                                {4{b[7:0]}}});
                end
                OpBeq, OpBne: begin
                    wr = 1'b0;
                    if ((a == b) ^ (instr[31:26] == 6'h05)) begin
                        nextNpc = pc4 + {simm[29:0], 2'b00};
                    end
                end
                OpJ: begin
                    wr      = 1'b0;
                    nextNpc = {pc4[31:28], instr[25:0], 2'b00};
                end
                OpJal: begin
                    wnum    = 5'd31;     // link register
                    wdata   = pc + 32'd8;  // return past the delay slot
                    nextNpc = {pc4[31:28], instr[25:0], 2'b00};
                end
                default: wr = 1'b0;
            endcase
            if (wr && wnum != 5'd0) begin
                regs[wnum] = wdata;
                expRegs.push_back(regWriteT'{pc, wnum, wdata});
            end
            pc  = npc;
            npc = nextNpc;
        end
    endtask

    task automatic driveStalls();
        iCacheStall_i = ($urandom % 100) < 15;
        dCacheStall_i = ($urandom % 100) < 15;
    endtask

    // inputs settle 1 ns after the edge, so the half cycle is stable
    always @(negedge clk) begin : monitor
        regWriteT w;
        storeT    s;
        if (!reset_i) begin
            if (debugWbRfWen_o != 4'b0000) begin
                if (expRegs.size() == 0) begin
                    stopWithError("register write seen after the last expected one");
                end
                w = expRegs.pop_front();
                compareValue("debugWbRfWen_o", 32'(debugWbRfWen_o), 32'h0000_000f);
                compareValue("debugWbPc_o", debugWbPc_o, w.pc);
                compareValue("debugWbRfWnum_o", 32'(debugWbRfWnum_o), 32'(w.num));
                compareValue("debugWbRfWdata_o", debugWbRfWdata_o, w.data);
            end
            if (memEn_o && memWriteSel_o != 4'b0000 && !iCacheStall_i && !dCacheStall_i) begin
                if (expStores.size() == 0) begin
                    stopWithError("store seen after the last expected one");
                end
                s = expStores.pop_front();
                compareValue("memAddr_o", memAddr_o, s.addr);
                compareValue("memWriteSel_o", 32'(memWriteSel_o), 32'(s.sel));
                compareValue("memWdata_o", memWdata_o, s.data);
                // nothing reads the word again before the coming edge
                for (int b = 0; b < 4; b++) begin
                    if (memWriteSel_o[b]) begin
                        dmem[memAddr_o[5:2]][8*b +: 8] = memWdata_o[8*b +: 8];
                    end
                end
            end
        end
    end

    initial begin
        repeat (WatchdogCycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, the DUT stopped retiring", WatchdogCycles);
        $display("TEST FAIL");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        reset_i       = 1'b1;
        iCacheStall_i = 1'b0;
        dCacheStall_i = 1'b0;
        void'($urandom(32'h7f3d));
        genProgram();
        for (int i = 0; i < DmemWords; i++) begin
            dmem[i] = fillWord(i);
        end
        runModel();
        $display("model expects %0d register writes and %0d stores",
                 expRegs.size(), expStores.size());
        repeat (ResetCycles) begin
            @(posedge clk);
            #1;
            compareValue("instEn_o", 32'(instEn_o), 32'd0);
            compareValue("memEn_o", 32'(memEn_o), 32'd0);
            compareValue("debugWbRfWen_o", 32'(debugWbRfWen_o), 32'd0);
        end
        reset_i = 1'b0;
        @(negedge clk);
        compareValue("pcF_o", pcF_o, ResetPc);  // first fetch
        compareValue("instEn_o", 32'(instEn_o), 32'd1);
        while (expRegs.size() != 0 || expStores.size() != 0) begin
            @(posedge clk);
            #1;
            driveStalls();
        end
        // parked on the self-jump, the monitor flags any further write
        repeat (DrainCycles) begin
            @(posedge clk);
            #1;
            driveStalls();
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== build.f ====
src/mipsIsaPkg.sv
src/pipePkg.sv
src/fetchStage.sv
src/decodeUnit.sv
src/regFile.sv
src/alu.sv
src/hazardUnit.sv
src/memAccess.sv
src/datapath.sv
tests/datapathTb.sv

// ==== run.sh ====
#!/bin/sh
# compile the datapath testbench with Verilator and run it
# the simulation binary exits nonzero on $fatal, which ends the script with failure
set -e
cd "$(dirname "$0")"
verilator --binary -j 0 -f build.f --top-module datapathTb -o datapathSim
./obj_dir/datapathSim
